// ==== design/lsq_params.svh ====
`ifndef LSQ_PARAMS_SVH
`define LSQ_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Queue depths

// Load queue and load address FIFO, one entry per ID
`define LSQ_LQ_DEPTH 8

// Store queue and store address FIFO
`define LSQ_SQ_DEPTH 4

//////////////////////////////////////////////////////////////////////
// Field widths

`define LSQ_ID_W 3
`define LSQ_OFFSET_W 12
`define LSQ_PAGE_W 20

// Folded offset hash used for load/store collision checks
`define LSQ_HASH_W 5

`endif

// ==== design/lsq_pkg.sv ====
`include "lsq_params.svh"

package lsq_pkg;

    //////////////////////////////////////////////////////////////////////
    // Offset hash
    //
    // Folds the word part of the page offset into LSQ_HASH_W bits
    // Bits 1..0 are byte lanes and do not take part
    // Same word offset always gives the same hash
    // Different words may still alias, which only costs a stall

    function automatic logic [`LSQ_HASH_W-1:0] lsq_offset_hash(
        input logic [`LSQ_OFFSET_W-1:0] offset
    );
        logic [`LSQ_HASH_W-1:0] low_part;
        logic [`LSQ_HASH_W-1:0] high_part;
        low_part  = offset[6:2];
        high_part = offset[11:7];
        return low_part ^ high_part;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Full address assembly
    //
    // Physical page number from the address channel on top
    // Page offset from the operation itself below

    function automatic logic [31:0] lsq_full_addr(
        input logic [`LSQ_PAGE_W-1:0]   page,
        input logic [`LSQ_OFFSET_W-1:0] offset
    );
        logic [31:0] addr;
        addr = {page, offset};
        return addr;
    endfunction

endpackage

// ==== design/lsq_fifo.sv ====
`timescale 1ns/10ps

module lsq_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  logic [WIDTH-1:0] wdata,
    input  logic             pop,
    output logic             valid,
    output logic [WIDTH-1:0] rdata,
    output logic             full
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Wrapping increment, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Push into a full FIFO and pop of an empty one are ignored
    assign do_push = push & ~full;
    assign do_pop  = pop & valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            // Count moves only when exactly one side acts
            if (do_push & ~do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop & ~do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage array
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // Head is visible one cycle after its push
    assign rdata = mem[rd_ptr];
    assign valid = (count != '0);
    assign full  = (count == CNT_W'(DEPTH));

endmodule

// ==== design/store_queue.sv ====
`timescale 1ns/10ps

`include "lsq_params.svh"

module store_queue
    import lsq_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              push,
    input  logic [`LSQ_OFFSET_W-1:0]          offset,
    input  logic [31:0]                       wdata,
    input  logic [3:0]                        be,
    input  logic                              retire,
    input  logic [`LSQ_OFFSET_W-1:0]          load_offset,
    input  logic                              pop,
    output logic                              valid,
    output logic [`LSQ_OFFSET_W-1:0]          head_offset,
    output logic [31:0]                       head_wdata,
    output logic [3:0]                        head_be,
    output logic                              full,
    output logic                              empty,
    output logic                              collision,
    output logic [$clog2(`LSQ_SQ_DEPTH)-1:0]  tail,
    output logic [$clog2(`LSQ_SQ_DEPTH)-1:0]  head
);
    localparam int DEPTH = `LSQ_SQ_DEPTH;
    localparam int IDX_W = $clog2(DEPTH);

    // Per-entry payload
    logic [`LSQ_OFFSET_W-1:0] offset_q [DEPTH];
    logic [31:0]              wdata_q  [DEPTH];
    logic [3:0]               be_q     [DEPTH];
    logic [`LSQ_HASH_W-1:0]   hash_q   [DEPTH];

    // Per-entry state
    logic [DEPTH-1:0] occupied;
    logic [DEPTH-1:0] retired;

    logic [IDX_W-1:0] head_ptr;
    logic [IDX_W-1:0] tail_ptr;
    logic [IDX_W-1:0] retire_ptr;

    logic [`LSQ_HASH_W-1:0] load_hash;
    logic [DEPTH-1:0]       hash_match;
    logic                   do_push;
    logic                   do_pop;

    function automatic logic [IDX_W-1:0] idx_inc(input logic [IDX_W-1:0] idx);
        if (idx == IDX_W'(DEPTH - 1)) begin
            return '0;
        end
        return idx + 1'b1;
    endfunction

    assign do_push = push & ~full;
    assign do_pop  = pop & valid;

    //////////////////////////////////////////////////////////////////////
    // Entry tracking

    // Retire walks its own pointer in program order
    // It never passes the tail, so it never hits a slot being pushed
    always_ff @(posedge clk) begin
        if (rst) begin
            occupied   <= '0;
            retired    <= '0;
            head_ptr   <= '0;
            tail_ptr   <= '0;
            retire_ptr <= '0;
        end else begin
            if (do_pop) begin
                occupied[head_ptr] <= 1'b0;
                retired[head_ptr]  <= 1'b0;
                head_ptr           <= idx_inc(head_ptr);
            end
            if (do_push) begin
                occupied[tail_ptr] <= 1'b1;
                retired[tail_ptr]  <= 1'b0;
                tail_ptr           <= idx_inc(tail_ptr);
            end
            if (retire) begin
                retired[retire_ptr] <= 1'b1;
                retire_ptr          <= idx_inc(retire_ptr);
            end
        end
    end

    // Payload and hash written at push
    always_ff @(posedge clk) begin
        if (do_push) begin
            offset_q[tail_ptr] <= offset;
            wdata_q[tail_ptr]  <= wdata;
            be_q[tail_ptr]     <= be;
            hash_q[tail_ptr]   <= lsq_offset_hash(offset);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Collision check for the load being pushed

    assign load_hash = lsq_offset_hash(load_offset);

    // Any occupied store with the same hash, retired or not
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            hash_match[i] = occupied[i] & (hash_q[i] == load_hash);
        end
    end

    assign collision = |hash_match;

    //////////////////////////////////////////////////////////////////////
    // Head and status

    // Registered retire flag, so issue starts the cycle after the pulse
    assign valid       = retired[head_ptr];
    assign head_offset = offset_q[head_ptr];
    assign head_wdata  = wdata_q[head_ptr];
    assign head_be     = be_q[head_ptr];

    assign full  = &occupied;
    assign empty = ~|occupied;
    assign tail  = tail_ptr;
    assign head  = head_ptr;

endmodule

// ==== design/load_store_queue.sv ====
`timescale 1ns/10ps

`include "lsq_params.svh"

module load_store_queue
    import lsq_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       push,
    input  logic                       is_store,
    input  logic [`LSQ_OFFSET_W-1:0]   offset,
    input  logic [`LSQ_ID_W-1:0]       id,
    input  logic [2:0]                 fn3,
    input  logic [31:0]                wdata,
    input  logic [3:0]                 be,
    input  logic                       addr_push,
    input  logic                       addr_is_store,
    input  logic [`LSQ_PAGE_W-1:0]     page,
    input  logic                       discard,
    input  logic                       retire,
    input  logic                       load_pop,
    input  logic                       store_pop,
    output logic                       full,
    output logic                       load_valid,
    output logic [31:0]                load_addr,
    output logic [2:0]                 load_fn3,
    output logic [`LSQ_ID_W-1:0]       load_id,
    output logic                       store_valid,
    output logic [31:0]                store_addr,
    output logic [31:0]                store_wdata,
    output logic [3:0]                 store_be,
    output logic                       empty,
    output logic                       sq_empty
);
    localparam int SQ_IDX_W     = $clog2(`LSQ_SQ_DEPTH);
    localparam int LQ_ENTRY_W   = `LSQ_OFFSET_W + `LSQ_ID_W + 3 + 1 + SQ_IDX_W;
    localparam int ADDR_ENTRY_W = `LSQ_PAGE_W + 1;

    // Load queue
    logic                     lq_push;
    logic                     lq_pop;
    logic                     lq_valid;
    logic                     lq_full;
    logic [LQ_ENTRY_W-1:0]    lq_wdata;
    logic [LQ_ENTRY_W-1:0]    lq_rdata;
    logic [`LSQ_OFFSET_W-1:0] lq_offset;
    logic [`LSQ_ID_W-1:0]     lq_id;
    logic [2:0]               lq_fn3;
    logic                     lq_collision;
    logic [SQ_IDX_W-1:0]      lq_sq_tail;
    logic                     load_blocked;
    logic                     lq_drop;

    // Load address FIFO
    logic                     lq_addr_in;
    logic                     lq_addr_push;
    logic                     lq_addr_valid;
    logic [ADDR_ENTRY_W-1:0]  lq_addr_rdata;
    logic                     lq_addr_present;
    logic [`LSQ_PAGE_W-1:0]   lq_page;
    logic                     lq_discard;

    // Store queue
    logic                     sq_push;
    logic                     sq_pop;
    logic                     sq_valid;
    logic                     sq_full;
    logic                     sq_collision;
    logic [SQ_IDX_W-1:0]      sq_tail;
    logic [SQ_IDX_W-1:0]      sq_head;
    logic [`LSQ_OFFSET_W-1:0] sq_offset;
    logic                     sq_drop;

    // Store address FIFO
    logic                     sq_addr_in;
    logic                     sq_addr_push;
    logic                     sq_addr_valid;
    logic [ADDR_ENTRY_W-1:0]  sq_addr_rdata;
    logic                     sq_addr_present;
    logic [`LSQ_PAGE_W-1:0]   sq_page;
    logic                     sq_discard;

    //////////////////////////////////////////////////////////////////////
    // Push routing

    assign lq_push    = push & ~is_store;
    assign sq_push    = push & is_store;
    assign lq_addr_in = addr_push & ~addr_is_store;
    assign sq_addr_in = addr_push & addr_is_store;

    // Either queue out of entries stops all pushes
    assign full = lq_full | sq_full;

    //////////////////////////////////////////////////////////////////////
    // Load side

    // Collision and store tail captured with the load
    assign lq_wdata = {offset, id, fn3, sq_collision, sq_tail};
    assign {lq_offset, lq_id, lq_fn3, lq_collision, lq_sq_tail} = lq_rdata;

    lsq_fifo #(
        .WIDTH (LQ_ENTRY_W),
        .DEPTH (`LSQ_LQ_DEPTH)
    ) u_load_queue (
        .clk   (clk),
        .rst   (rst),
        .push  (lq_push),
        .wdata (lq_wdata),
        .pop   (lq_pop),
        .valid (lq_valid),
        .rdata (lq_rdata),
        .full  (lq_full)
    );

    // Address consumed in the same cycle skips the FIFO
    assign lq_addr_push = lq_addr_in & ~(lq_pop & ~lq_addr_valid);

    lsq_fifo #(
        .WIDTH (ADDR_ENTRY_W),
        .DEPTH (`LSQ_LQ_DEPTH)
    ) u_load_addr_fifo (
        .clk   (clk),
        .rst   (rst),
        .push  (lq_addr_push),
        .wdata ({page, discard}),
        .pop   (lq_pop),
        .valid (lq_addr_valid),
        .rdata (lq_addr_rdata),
        .full  ()
    );

    // Bypass mux for an address arriving while the FIFO is empty
    // That address then belongs to the head load
    assign lq_addr_present = lq_addr_valid | lq_addr_in;
    assign lq_page    = lq_addr_valid ? lq_addr_rdata[ADDR_ENTRY_W-1:1] : page;
    assign lq_discard = lq_addr_valid ? lq_addr_rdata[0] : discard;

    // Older matching stores still ahead of the store head
    assign load_blocked = lq_collision & (lq_sq_tail != sq_head);

    assign lq_drop = lq_valid & lq_addr_present & lq_discard;
    assign lq_pop  = load_pop | lq_drop;

    assign load_valid = lq_valid & lq_addr_present & ~lq_discard & ~load_blocked;
    assign load_addr  = lsq_full_addr(lq_page, lq_offset);
    assign load_fn3   = lq_fn3;
    assign load_id    = lq_id;

    //////////////////////////////////////////////////////////////////////
    // Store side

    store_queue u_store_queue (
        .clk         (clk),
        .rst         (rst),
        .push        (sq_push),
        .offset      (offset),
        .wdata       (wdata),
        .be          (be),
        .retire      (retire),
        .load_offset (offset),
        .pop         (sq_pop),
        .valid       (sq_valid),
        .head_offset (sq_offset),
        .head_wdata  (store_wdata),
        .head_be     (store_be),
        .full        (sq_full),
        .empty       (sq_empty),
        .collision   (sq_collision),
        .tail        (sq_tail),
        .head        (sq_head)
    );

    assign sq_addr_push = sq_addr_in & ~(sq_pop & ~sq_addr_valid);

    lsq_fifo #(
        .WIDTH (ADDR_ENTRY_W),
        .DEPTH (`LSQ_SQ_DEPTH)
    ) u_store_addr_fifo (
        .clk   (clk),
        .rst   (rst),
        .push  (sq_addr_push),
        .wdata ({page, discard}),
        .pop   (sq_pop),
        .valid (sq_addr_valid),
        .rdata (sq_addr_rdata),
        .full  ()
    );

    assign sq_addr_present = sq_addr_valid | sq_addr_in;
    assign sq_page    = sq_addr_valid ? sq_addr_rdata[ADDR_ENTRY_W-1:1] : page;
    assign sq_discard = sq_addr_valid ? sq_addr_rdata[0] : discard;

    // Discarded store still waits for retire before it is dropped
    assign sq_drop = sq_valid & sq_addr_present & sq_discard;
    assign sq_pop  = store_pop | sq_drop;

    assign store_valid = sq_valid & sq_addr_present & ~sq_discard;
    assign store_addr  = lsq_full_addr(sq_page, sq_offset);

    //////////////////////////////////////////////////////////////////////
    // Status

    assign empty = ~lq_valid & sq_empty;

endmodule

// ==== tb/lsq_tb.sv ====
`timescale 1ns/10ps

`include "lsq_params.svh"

module lsq_tb;

    logic                     clk;
    logic                     rst;
    logic                     push;
    logic                     is_store;
    logic [`LSQ_OFFSET_W-1:0] offset;
    logic [`LSQ_ID_W-1:0]     id;
    logic [2:0]               fn3;
    logic [31:0]              wdata;
    logic [3:0]               be;
    logic                     addr_push;
    logic                     addr_is_store;
    logic [`LSQ_PAGE_W-1:0]   page;
    logic                     discard;
    logic                     retire;
    logic                     load_pop;
    logic                     store_pop;
    logic                     full;
    logic                     load_valid;
    logic [31:0]              load_addr;
    logic [2:0]               load_fn3;
    logic [`LSQ_ID_W-1:0]     load_id;
    logic                     store_valid;
    logic [31:0]              store_addr;
    logic [31:0]              store_wdata;
    logic [3:0]               store_be;
    logic                     empty;
    logic                     sq_empty;

    // Expected requests, one queue set per kind
    logic [31:0] exp_load_addr[$];
    logic [31:0] exp_load_id[$];
    logic [31:0] exp_load_fn3[$];
    logic [31:0] exp_load_min[$];
    logic [31:0] exp_load_max[$];
    logic [31:0] exp_store_addr[$];
    logic [31:0] exp_store_wdata[$];
    logic [31:0] exp_store_be[$];

    // Output snapshots taken mid-cycle
    logic        snap_lv;
    logic        snap_sv;
    logic [31:0] snap_load_addr;
    logic [2:0]  snap_load_fn3;
    logic [2:0]  snap_load_id;
    logic [31:0] snap_store_addr;
    logic [31:0] snap_store_wdata;
    logic [3:0]  snap_store_be;
    logic        full_seen;

    logic        pushed_last;
    logic        stall;
    int          st_issued;
    int          test_num;
    int          test_errors;
    int          error_count;
    int          failed_tests;
    int          cycle_count;
    int          cycle_limit;
    int          fd;

    load_store_queue u_load_store_queue (
        .clk           (clk),
        .rst           (rst),
        .push          (push),
        .is_store      (is_store),
        .offset        (offset),
        .id            (id),
        .fn3           (fn3),
        .wdata         (wdata),
        .be            (be),
        .addr_push     (addr_push),
        .addr_is_store (addr_is_store),
        .page          (page),
        .discard       (discard),
        .retire        (retire),
        .load_pop      (load_pop),
        .store_pop     (store_pop),
        .full          (full),
        .load_valid    (load_valid),
        .load_addr     (load_addr),
        .load_fn3      (load_fn3),
        .load_id       (load_id),
        .store_valid   (store_valid),
        .store_addr    (store_addr),
        .store_wdata   (store_wdata),
        .store_be      (store_be),
        .empty         (empty),
        .sq_empty      (sq_empty)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Checking

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] test %0d %s got %h expected %h", test_num, name, got, exp);
            test_errors++;
            error_count++;
        end
    endtask

    task automatic record_load();
        if (exp_load_addr.size() == 0) begin
            $display("test %0d: load to %h issued but none was expected",
                     test_num, snap_load_addr);
            test_errors++;
            error_count++;
        end else begin
            check_value("load_addr", snap_load_addr, exp_load_addr.pop_front());
            check_value("load_id", 32'(snap_load_id), exp_load_id.pop_front());
            check_value("load_fn3", 32'(snap_load_fn3), exp_load_fn3.pop_front());
            // Stores issued so far bound the collision ordering
            if (st_issued < int'(exp_load_min[0]) || st_issued > int'(exp_load_max[0])) begin
                $display("test %0d: load id %0d issued after %0d stores, expected %0d to %0d",
                         test_num, snap_load_id, st_issued, exp_load_min[0], exp_load_max[0]);
                test_errors++;
                error_count++;
            end
            void'(exp_load_min.pop_front());
            void'(exp_load_max.pop_front());
        end
    endtask

    task automatic record_store();
        st_issued++;
        if (exp_store_addr.size() == 0) begin
            $display("test %0d: store to %h issued but none was expected",
                     test_num, snap_store_addr);
            test_errors++;
            error_count++;
        end else begin
            check_value("store_addr", snap_store_addr, exp_store_addr.pop_front());
            check_value("store_wdata", snap_store_wdata, exp_store_wdata.pop_front());
            check_value("store_be", 32'(snap_store_be), exp_store_be.pop_front());
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Memory side

    always @(negedge clk) begin
        snap_lv          = load_valid;
        snap_sv          = store_valid;
        snap_load_addr   = load_addr;
        snap_load_fn3    = load_fn3;
        snap_load_id     = load_id;
        snap_store_addr  = store_addr;
        snap_store_wdata = store_wdata;
        snap_store_be    = store_be;
        full_seen        = full;
    end

    // One pop per cycle, loads first
    // A cycle after any pop is skipped so the snapshot is current
    always @(posedge clk) begin
        logic withhold;
        withhold = stall || ($urandom % 4 == 0);
        load_pop  <= 1'b0;
        store_pop <= 1'b0;
        if (!rst && !load_pop && !store_pop && !withhold) begin
            if (snap_lv) begin
                load_pop <= 1'b1;
                record_load();
            end else if (snap_sv) begin
                store_pop <= 1'b1;
                record_store();
            end
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Run stopped at the cycle limit of %0d", cycle_limit);
            $display("Testbench failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus

    // Step to the next rising edge and drop the single-cycle pulses
    task automatic advance();
        @(posedge clk);
        pushed_last = push;
        push      <= 1'b0;
        addr_push <= 1'b0;
        retire    <= 1'b0;
    endtask

    task automatic end_test();
        int wait_cnt;
        wait_cnt = 0;
        while ((exp_load_addr.size() + exp_store_addr.size()) != 0 && wait_cnt < 300) begin
            advance();
            wait_cnt++;
        end
        if ((exp_load_addr.size() + exp_store_addr.size()) != 0) begin
            $display("test %0d: %0d loads and %0d stores were never issued", test_num,
                     exp_load_addr.size(), exp_store_addr.size());
            test_errors++;
            error_count++;
        end
        // Quiet period catches requests that should have been dropped
        repeat (10) advance();
        @(negedge clk);
        check_value("empty", 32'(empty), 32'd1);
        check_value("sq_empty", 32'(sq_empty), 32'd1);
        advance();
        if (test_errors == 0) begin
            $display("test %0d: ok", test_num);
        end else begin
            $display("test %0d: %0d errors", test_num, test_errors);
            failed_tests++;
        end
    endtask

    task automatic run_file();
        string       line;
        string       rest;
        byte         cmd;
        int          n;
        logic [31:0] f[7];
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1) begin
                cmd  = line.getc(0);
                rest = line.substr(1, line.len() - 1);
                case (cmd)
                    "T": begin
                        test_num++;
                        test_errors = 0;
                        st_issued   = 0;
                    end
                    "L": begin
                        n = $sscanf(rest, "%h %h %h %h %h", f[0], f[1], f[2], f[3], f[4]);
                        exp_load_addr.push_back(f[0]);
                        exp_load_id.push_back(f[1]);
                        exp_load_fn3.push_back(f[2]);
                        exp_load_min.push_back(f[3]);
                        exp_load_max.push_back(f[4]);
                    end
                    "S": begin
                        n = $sscanf(rest, "%h %h %h", f[0], f[1], f[2]);
                        exp_store_addr.push_back(f[0]);
                        exp_store_wdata.push_back(f[1]);
                        exp_store_be.push_back(f[2]);
                    end
                    "P": begin
                        n = $sscanf(rest, "%h %h %h %h %h %h %h",
                                    f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
                        repeat (f[0]) advance();
                        // Wait until no push is in flight and full is low
                        while (pushed_last || full_seen) advance();
                        push     <= 1'b1;
                        is_store <= f[1][0];
                        offset   <= f[2][11:0];
                        id       <= f[3][2:0];
                        fn3      <= f[4][2:0];
                        wdata    <= f[5];
                        be       <= f[6][3:0];
                    end
                    "A": begin
                        n = $sscanf(rest, "%h %h %h %h", f[0], f[1], f[2], f[3]);
                        repeat (f[0]) advance();
                        addr_push     <= 1'b1;
                        addr_is_store <= f[1][0];
                        page          <= f[2][19:0];
                        discard       <= f[3][0];
                    end
                    "R": begin
                        n = $sscanf(rest, "%h", f[0]);
                        repeat (f[0]) advance();
                        retire <= 1'b1;
                    end
                    "H": begin
                        n = $sscanf(rest, "%h", f[0]);
                        stall <= f[0][0];
                    end
                    "F": begin
                        n = $sscanf(rest, "%h %h", f[0], f[1]);
                        repeat (f[0]) advance();
                        @(negedge clk);
                        check_value("full", 32'(full), f[1]);
                        advance();
                    end
                    "E": end_test();
                    default: ;
                endcase
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        string line;
        int    n;
        int    line_count;
        rst           = 1'b1;
        push          = 1'b0;
        is_store      = 1'b0;
        offset        = '0;
        id            = '0;
        fn3           = '0;
        wdata         = '0;
        be            = '0;
        addr_push     = 1'b0;
        addr_is_store = 1'b0;
        page          = '0;
        discard       = 1'b0;
        retire        = 1'b0;
        load_pop      = 1'b0;
        store_pop     = 1'b0;
        pushed_last   = 1'b0;
        stall         = 1'b0;
        st_issued     = 0;
        test_num      = 0;
        test_errors   = 0;
        error_count   = 0;
        failed_tests  = 0;
        cycle_count   = 0;
        cycle_limit   = 0;
        line_count    = 0;
        n = $urandom(15234);
        fd = $fopen("tb/lsq_tests.txt", "r");
        if (fd == 0) begin
            $display("Test data file tb/lsq_tests.txt could not be opened");
            $display("Testbench failed");
            $finish;
        end else begin
            // Run length limit from the size of the test file
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                line_count++;
            end
            $fclose(fd);
            cycle_limit = 200 * line_count;
            fd = $fopen("tb/lsq_tests.txt", "r");

            repeat (4) @(posedge clk);
            @(negedge clk);
            check_value("empty", 32'(empty), 32'd1);
            check_value("sq_empty", 32'(sq_empty), 32'd1);
            check_value("full", 32'(full), 32'd0);
            check_value("load_valid", 32'(load_valid), 32'd0);
            check_value("store_valid", 32'(store_valid), 32'd0);
            @(posedge clk);
            rst <= 1'b0;

            run_file();
            $fclose(fd);
            $display("tests %0d, failed %0d, errors %0d", test_num, failed_tests, error_count);
            if (error_count == 0) begin
                $display("Testbench passed");
            end else begin
                $display("Testbench failed");
            end
            $finish;
        end
    end

endmodule

// ==== flist.f ====
+incdir+design
design/lsq_pkg.sv
design/lsq_fifo.sv
design/store_queue.sv
design/load_store_queue.sv
tb/lsq_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -j 0 --top-module lsq_tb -f flist.f -o lsq_sim

./obj_dir/lsq_sim | tee sim.log

if grep -q "Testbench failed" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi

if ! grep -q "Testbench passed" sim.log; then
    echo "Simulation ended without a result, see sim.log"
    exit 1
fi

// ==== tb/lsq_tests.txt ====
# T begin test | L addr id fn3 min_st max_st | S addr wdata be   (expected, in issue order)
# P dly kind off id fn3 wdata be | A dly kind page discard | R dly | H stall | F dly full | E
# Loads in order, address in the same cycle and later
T
L 12345008 1 2 0 0
L 0abcd010 2 0 0 0
L 00777ffc 3 4 0 0
P 1 0 008 1 2 0 0
A 0 0 12345 0
P 1 0 010 2 0 0 0
P 1 0 ffc 3 4 0 0
A 3 0 0abcd 0
A 1 0 00777 0
E
# Stores wait for retire
T
S 00010100 11223344 f
S 00020204 aabbccdd 3
P 1 1 100 0 0 11223344 f
A 0 1 00010 0
P 1 1 204 0 0 aabbccdd 3
A 1 1 00020 0
R 3
R 5
E
# Discarded load and store
T
L 00030040 4 2 0 1
S 00050300 cafef00d c
P 1 0 020 3 2 0 0
A 0 0 00033 1
P 1 0 040 4 2 0 0
A 1 0 00030 0
P 1 1 2f0 0 0 deadbeef f
A 1 1 00044 1
P 1 1 300 0 0 cafef00d c
A 1 1 00050 0
R 1
R 1
E
# Collision, word match and hash alias wait, other word passes
T
S 00060084 01020304 f
L 000700a0 5 2 0 0
L 00070084 6 2 1 1
L 00070000 7 1 1 1
P 1 1 084 0 0 01020304 f
A 0 1 00060 0
P 1 0 0a0 5 2 0 0
A 0 0 00070 0
P 1 0 084 6 2 0 0
A 0 0 00070 0
P 1 0 000 7 1 0 0
A 0 0 00070 0
R 20
E
# Back-pressure, four stores fill the store queue
T
S 00100000 00000001 1
S 00100010 00000002 2
S 00100020 00000003 4
S 00100030 00000004 8
H 1
P 1 1 000 0 0 00000001 1
A 0 1 00100 0
R 1
P 1 1 010 0 0 00000002 2
A 0 1 00100 0
R 1
P 1 1 020 0 0 00000003 4
A 0 1 00100 0
R 1
P 1 1 030 0 0 00000004 8
A 0 1 00100 0
R 1
F 2 1
H 0
E
